// ==== hdl/rv_isa_pkg.sv ====
package rv_isa_pkg;

  localparam int xlen = 64;

  // major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_reg32  = 7'b0111011;

  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_sll = 3'b001;
  localparam logic [2:0] f3_bne = 3'b001;
  localparam logic [2:0] f3_lw  = 3'b010;
  localparam logic [2:0] f3_d   = 3'b011;
  localparam logic [2:0] f3_lbu = 3'b100;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_sub  = 7'b0100000;

  localparam logic [31:0] ebreak_word = 32'h0010_0073;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_addw,
    alu_sll,
    alu_pass_b,
    alu_ne
  } alu_op_e;

  typedef enum logic [2:0] {
    mem_none,
    mem_ld,
    mem_lw,
    mem_lbu,
    mem_sd
  } mem_op_e;

  typedef enum logic [1:0] {
    wb_alu,
    wb_link,
    wb_mem,
    wb_none
  } wb_sel_e;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [xlen-1:0] imm;
    alu_op_e         alu_op;
    logic            a_is_pc;
    logic            b_is_imm;
    mem_op_e         mem_op;
    wb_sel_e         wb_sel;
    logic            is_jal;
    logic            is_jalr;
    logic            is_bne;
    logic            is_ebreak;
  } uop_t;

endpackage

// ==== hdl/rv_link_pkg.sv ====
package rv_link_pkg;

  localparam int inst_credits   = 4;
  localparam int retire_credits = 4;

  // counters must hold the full initial value
  localparam int inst_credit_w   = $clog2(inst_credits + 1);
  localparam int retire_credit_w = $clog2(retire_credits + 1);

  typedef struct packed {
    logic [63:0] pc;
    logic [31:0] word;
  } inst_msg_t;

  typedef struct packed {
    logic [63:0]          pc;
    logic [4:0]           rd;
    rv_isa_pkg::mem_op_e  mem_op;
    rv_isa_pkg::wb_sel_e  wb_sel;
    logic                 is_ebreak;
    logic [63:0]          alu;
    logic [63:0]          store_data;
    logic [63:0]          mem_addr;
    logic [63:0]          dnpc;
  } ex_rec_t;

  typedef struct packed {
    logic [63:0] pc;
    logic [63:0] dnpc;
    logic [4:0]  rd;
    logic        wen;
    logic [63:0] wdata;
    logic        halt;
    logic        halt_status;
  } retire_msg_t;

  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [63:0] value;
  } bypass_t;

endpackage

// ==== hdl/credit_fifo.sv ====
`timescale 1ns/100ps

module credit_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     empty,
  output logic     credit
);

  localparam int ptr_w = $clog2(depth);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;

  assign empty = (count == '0);
  assign head  = mem[rd_ptr];

  // ring wraps at depth, which need not be a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      credit <= pop;
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

// ==== hdl/rv_decode.sv ====
`timescale 1ns/100ps

module rv_decode (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   empty,
  input  rv_link_pkg::inst_msg_t head,
  input  logic                   retire_credit,
  output logic                   pop,
  output rv_isa_pkg::uop_t       uop,
  output logic                   uop_valid,
  output logic                   retire_issue
);

  logic [rv_link_pkg::retire_credit_w-1:0] credits;
  logic [31:0]      word;
  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [63:0]      imm_i;
  logic [63:0]      imm_u;
  logic [63:0]      imm_j;
  logic [63:0]      imm_b;
  logic [63:0]      imm_s;
  rv_isa_pkg::uop_t dec;

  assign pop          = !empty && (credits != '0);
  assign retire_issue = pop;

  assign word   = head.word;
  assign opcode = word[6:0];
  assign funct3 = word[14:12];
  assign funct7 = word[31:25];

  assign imm_i = {{52{word[31]}}, word[31:20]};
  assign imm_u = {{32{word[31]}}, word[31:12], 12'b0};
  assign imm_j = {{43{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
  assign imm_b = {{51{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
  assign imm_s = {{52{word[31]}}, word[31:25], word[11:7]};

  // unknown words fall through as no-ops with rd cleared
  always_comb begin
    dec        = '0;
    dec.pc     = head.pc;
    dec.rs1    = word[19:15];
    dec.rs2    = word[24:20];
    dec.alu_op = rv_isa_pkg::alu_add;
    dec.mem_op = rv_isa_pkg::mem_none;
    dec.wb_sel = rv_isa_pkg::wb_none;
    case (opcode)
      rv_isa_pkg::op_lui: begin
        dec.rd       = word[11:7];
        dec.imm      = imm_u;
        dec.b_is_imm = 1'b1;
        dec.alu_op   = rv_isa_pkg::alu_pass_b;
        dec.wb_sel   = rv_isa_pkg::wb_alu;
      end
      rv_isa_pkg::op_auipc: begin
        dec.rd       = word[11:7];
        dec.imm      = imm_u;
        dec.a_is_pc  = 1'b1;
        dec.b_is_imm = 1'b1;
        dec.wb_sel   = rv_isa_pkg::wb_alu;
      end
      rv_isa_pkg::op_jal: begin
        dec.rd     = word[11:7];
        dec.imm    = imm_j;
        dec.is_jal = 1'b1;
        dec.wb_sel = rv_isa_pkg::wb_link;
      end
      rv_isa_pkg::op_jalr: begin
        if (funct3 == rv_isa_pkg::f3_add) begin
          dec.rd      = word[11:7];
          dec.imm     = imm_i;
          dec.is_jalr = 1'b1;
          dec.wb_sel  = rv_isa_pkg::wb_link;
        end
      end
      rv_isa_pkg::op_branch: begin
        if (funct3 == rv_isa_pkg::f3_bne) begin
          dec.imm    = imm_b;
          dec.alu_op = rv_isa_pkg::alu_ne;
          dec.is_bne = 1'b1;
        end
      end
      rv_isa_pkg::op_load: begin
        dec.rd  = word[11:7];
        dec.imm = imm_i;
        case (funct3)
          rv_isa_pkg::f3_d:   dec.mem_op = rv_isa_pkg::mem_ld;
          rv_isa_pkg::f3_lw:  dec.mem_op = rv_isa_pkg::mem_lw;
          rv_isa_pkg::f3_lbu: dec.mem_op = rv_isa_pkg::mem_lbu;
          default:            dec.rd     = 5'd0;
        endcase
        if (dec.mem_op != rv_isa_pkg::mem_none) begin
          dec.wb_sel = rv_isa_pkg::wb_mem;
        end
      end
      rv_isa_pkg::op_store: begin
        if (funct3 == rv_isa_pkg::f3_d) begin
          dec.imm    = imm_s;
          dec.mem_op = rv_isa_pkg::mem_sd;
        end
      end
      rv_isa_pkg::op_imm: begin
        if (funct3 == rv_isa_pkg::f3_add) begin
          dec.rd       = word[11:7];
          dec.imm      = imm_i;
          dec.b_is_imm = 1'b1;
          dec.wb_sel   = rv_isa_pkg::wb_alu;
        end else if (funct3 == rv_isa_pkg::f3_sll && word[31:26] == 6'b0) begin
          dec.rd       = word[11:7];
          dec.imm      = imm_i;
          dec.b_is_imm = 1'b1;
          dec.alu_op   = rv_isa_pkg::alu_sll;
          dec.wb_sel   = rv_isa_pkg::wb_alu;
        end
      end
      rv_isa_pkg::op_reg: begin
        if (funct3 == rv_isa_pkg::f3_add && funct7 == rv_isa_pkg::f7_base) begin
          dec.rd     = word[11:7];
          dec.wb_sel = rv_isa_pkg::wb_alu;
        end else if (funct3 == rv_isa_pkg::f3_add && funct7 == rv_isa_pkg::f7_sub) begin
          dec.rd     = word[11:7];
          dec.alu_op = rv_isa_pkg::alu_sub;
          dec.wb_sel = rv_isa_pkg::wb_alu;
        end
      end
      rv_isa_pkg::op_reg32: begin
        if (funct3 == rv_isa_pkg::f3_add && funct7 == rv_isa_pkg::f7_base) begin
          dec.rd     = word[11:7];
          dec.alu_op = rv_isa_pkg::alu_addw;
          dec.wb_sel = rv_isa_pkg::wb_alu;
        end
      end
      default: begin
        dec.is_ebreak = (word == rv_isa_pkg::ebreak_word);
      end
    endcase
  end

  // retire slots: reserved at issue, returned by the consumer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits   <= rv_link_pkg::retire_credit_w'(rv_link_pkg::retire_credits);
      uop_valid <= 1'b0;
    end else begin
      uop_valid <= pop;
      if (pop && !retire_credit) begin
        credits <= credits - 1'b1;
      end else if (!pop && retire_credit) begin
        credits <= credits + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      uop <= dec;
    end
  end

endmodule

// ==== hdl/rv_execute.sv ====
`timescale 1ns/100ps

module rv_execute (
  input  logic                 clk,
  input  logic                 rst_n,
  input  rv_isa_pkg::uop_t     uop,
  input  logic                 uop_valid,
  input  logic [63:0]          rs1_val,
  input  logic [63:0]          rs2_val,
  input  rv_link_pkg::bypass_t bypass,
  output logic [4:0]           rs1_idx,
  output logic [4:0]           rs2_idx,
  output rv_link_pkg::ex_rec_t ex_rec,
  output logic                 ex_valid
);

  logic [63:0] rs1;
  logic [63:0] rs2;
  logic [63:0] op_a;
  logic [63:0] op_b;
  logic [63:0] alu;
  logic [31:0] sum_w;
  logic [63:0] addr;
  logic [63:0] snpc;
  logic [63:0] dnpc;

  assign rs1_idx = uop.rs1;
  assign rs2_idx = uop.rs2;

  // result stage writes at the coming edge, take its value now
  assign rs1 = (bypass.valid && bypass.rd == uop.rs1 && uop.rs1 != 5'd0) ?
               bypass.value : rs1_val;
  assign rs2 = (bypass.valid && bypass.rd == uop.rs2 && uop.rs2 != 5'd0) ?
               bypass.value : rs2_val;

  assign op_a  = uop.a_is_pc  ? uop.pc  : rs1;
  assign op_b  = uop.b_is_imm ? uop.imm : rs2;
  assign sum_w = op_a[31:0] + op_b[31:0];

  always_comb begin
    case (uop.alu_op)
      rv_isa_pkg::alu_sub:    alu = op_a - op_b;
      rv_isa_pkg::alu_addw:   alu = {{32{sum_w[31]}}, sum_w};
      rv_isa_pkg::alu_sll:    alu = op_a << op_b[5:0];
      rv_isa_pkg::alu_pass_b: alu = op_b;
      rv_isa_pkg::alu_ne:     alu = {63'b0, op_a != op_b};
      default:                alu = op_a + op_b;
    endcase
  end

  // also the jalr target before bit 0 is cleared
  assign addr = rs1 + uop.imm;
  assign snpc = uop.pc + 64'd4;

  always_comb begin
    if (uop.is_jal) begin
      dnpc = uop.pc + uop.imm;
    end else if (uop.is_jalr) begin
      dnpc = {addr[63:1], 1'b0};
    end else if (uop.is_bne && alu[0]) begin
      dnpc = uop.pc + uop.imm;
    end else begin
      dnpc = snpc;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= uop_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (uop_valid) begin
      ex_rec.pc         <= uop.pc;
      ex_rec.rd         <= uop.rd;
      ex_rec.mem_op     <= uop.mem_op;
      ex_rec.wb_sel     <= uop.wb_sel;
      ex_rec.is_ebreak  <= uop.is_ebreak;
      ex_rec.alu        <= alu;
      ex_rec.store_data <= rs2;
      ex_rec.mem_addr   <= addr;
      ex_rec.dnpc       <= dnpc;
    end
  end

endmodule

// ==== hdl/rv_result.sv ====
`timescale 1ns/100ps

module rv_result (
  input  logic                     clk,
  input  logic                     rst_n,
  input  rv_link_pkg::ex_rec_t     ex_rec,
  input  logic                     ex_valid,
  input  logic [4:0]               rs1_idx,
  input  logic [4:0]               rs2_idx,
  output logic [63:0]              rs1_val,
  output logic [63:0]              rs2_val,
  output rv_link_pkg::bypass_t     bypass,
  output rv_link_pkg::retire_msg_t retire,
  output logic                     retire_valid
);

  logic [63:0] regs [32];
  logic [63:0] dmem [64];
  logic [5:0]  mem_idx;
  logic [63:0] mem_word;
  logic [31:0] half;
  logic [7:0]  byte_val;
  logic [63:0] load_data;
  logic        wen;
  logic [63:0] wdata;
  rv_link_pkg::retire_msg_t msg;

  assign rs1_val = regs[rs1_idx];
  assign rs2_val = regs[rs2_idx];

  // doubleword index, byte lane from the low bits
  assign mem_idx  = ex_rec.mem_addr[8:3];
  assign mem_word = dmem[mem_idx];
  assign half     = ex_rec.mem_addr[2] ? mem_word[63:32] : mem_word[31:0];
  assign byte_val = mem_word[8*ex_rec.mem_addr[2:0] +: 8];

  always_comb begin
    case (ex_rec.mem_op)
      rv_isa_pkg::mem_lw:  load_data = {{32{half[31]}}, half};
      rv_isa_pkg::mem_lbu: load_data = {56'b0, byte_val};
      default:             load_data = mem_word;
    endcase
  end

  assign wen = (ex_rec.wb_sel != rv_isa_pkg::wb_none);

  always_comb begin
    case (ex_rec.wb_sel)
      rv_isa_pkg::wb_alu:  wdata = ex_rec.alu;
      rv_isa_pkg::wb_link: wdata = ex_rec.pc + 64'd4;
      rv_isa_pkg::wb_mem:  wdata = load_data;
      default:             wdata = '0;
    endcase
  end

  assign bypass.valid = ex_valid && wen;
  assign bypass.rd    = ex_rec.rd;
  assign bypass.value = wdata;

  always_comb begin
    msg.pc          = ex_rec.pc;
    msg.dnpc        = ex_rec.dnpc;
    msg.rd          = ex_rec.rd;
    msg.wen         = wen;
    msg.wdata       = wdata;
    msg.halt        = ex_rec.is_ebreak;
    // a0 carries the exit code
    msg.halt_status = ex_rec.is_ebreak && (regs[10] != 64'd0);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
      for (int i = 0; i < 64; i++) begin
        dmem[i] <= '0;
      end
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= ex_valid;
      // x0 never written
      if (ex_valid && wen && ex_rec.rd != 5'd0) begin
        regs[ex_rec.rd] <= wdata;
      end
      if (ex_valid && ex_rec.mem_op == rv_isa_pkg::mem_sd) begin
        dmem[mem_idx] <= ex_rec.store_data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid) begin
      retire <= msg;
    end
  end

endmodule

// ==== hdl/rv_core_top.sv ====
`timescale 1ns/100ps

module rv_core_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     inst_valid,
  input  rv_link_pkg::inst_msg_t   inst,
  output logic                     inst_credit,
  input  logic                     retire_credit,
  output logic                     retire_valid,
  output rv_link_pkg::retire_msg_t retire
);

  rv_link_pkg::inst_msg_t   in_head;
  logic                     in_empty;
  logic                     in_pop;
  rv_isa_pkg::uop_t         uop;
  logic                     uop_valid;
  logic [4:0]               rs1_idx;
  logic [4:0]               rs2_idx;
  logic [63:0]              rs1_val;
  logic [63:0]              rs2_val;
  rv_link_pkg::bypass_t     bypass;
  rv_link_pkg::ex_rec_t     ex_rec;
  logic                     ex_valid;
  rv_link_pkg::retire_msg_t res_msg;
  logic                     res_valid;
  logic                     ret_empty;
  logic [rv_link_pkg::retire_credit_w-1:0] out_credits;

  credit_fifo #(
    .payload_t (rv_link_pkg::inst_msg_t),
    .depth     (rv_link_pkg::inst_credits)
  ) u_in_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (inst_valid),
    .push_data (inst),
    .pop       (in_pop),
    .head      (in_head),
    .empty     (in_empty),
    .credit    (inst_credit)
  );

  rv_decode u_decode (
    .clk           (clk),
    .rst_n         (rst_n),
    .empty         (in_empty),
    .head          (in_head),
    .retire_credit (retire_credit),
    .pop           (in_pop),
    .uop           (uop),
    .uop_valid     (uop_valid),
    .retire_issue  ()
  );

  rv_execute u_execute (
    .clk       (clk),
    .rst_n     (rst_n),
    .uop       (uop),
    .uop_valid (uop_valid),
    .rs1_val   (rs1_val),
    .rs2_val   (rs2_val),
    .bypass    (bypass),
    .rs1_idx   (rs1_idx),
    .rs2_idx   (rs2_idx),
    .ex_rec    (ex_rec),
    .ex_valid  (ex_valid)
  );

  rv_result u_result (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_rec       (ex_rec),
    .ex_valid     (ex_valid),
    .rs1_idx      (rs1_idx),
    .rs2_idx      (rs2_idx),
    .rs1_val      (rs1_val),
    .rs2_val      (rs2_val),
    .bypass       (bypass),
    .retire       (res_msg),
    .retire_valid (res_valid)
  );

  // slots already reserved at issue, so this buffer cannot overflow
  credit_fifo #(
    .payload_t (rv_link_pkg::retire_msg_t),
    .depth     (rv_link_pkg::retire_credits)
  ) u_ret_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (res_valid),
    .push_data (res_msg),
    .pop       (retire_valid),
    .head      (retire),
    .empty     (ret_empty),
    .credit    ()
  );

  assign retire_valid = !ret_empty && (out_credits != '0);

  // consumer-side credits for the retire link
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_credits <= rv_link_pkg::retire_credit_w'(rv_link_pkg::retire_credits);
    end else if (retire_valid && !retire_credit) begin
      out_credits <= out_credits - 1'b1;
    end else if (!retire_valid && retire_credit) begin
      out_credits <= out_credits + 1'b1;
    end
  end

endmodule

// ==== sim/rv_core_chk.sv ====
`timescale 1ns/100ps

module rv_core_chk (
  input logic clk,
  input logic rst_n,
  input logic inst_valid,
  input logic inst_credit,
  input logic retire_valid,
  input logic retire_credit
);

  int unsigned errors = 0;
  int          src_credits;
  int          sink_credits;

  // credits held by the source and by the core on the retire side
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      src_credits  <= rv_link_pkg::inst_credits;
      sink_credits <= rv_link_pkg::retire_credits;
    end else begin
      src_credits  <= src_credits - int'(inst_valid) + int'(inst_credit);
      sink_credits <= sink_credits - int'(retire_valid) + int'(retire_credit);
    end
  end

  a_inst_credit: assert property (
    @(posedge clk) disable iff (!rst_n) inst_valid |-> src_credits > 0
  ) else begin
    errors = errors + 1;
    $error("instruction sent while the source held no credit");
  end

  a_retire_credit: assert property (
    @(posedge clk) disable iff (!rst_n) retire_valid |-> sink_credits > 0
  ) else begin
    errors = errors + 1;
    $error("retire record presented without a retire credit");
  end

  a_reset_quiet: assert property (
    @(posedge clk) !rst_n |=> (!inst_credit && !retire_valid)
  ) else begin
    errors = errors + 1;
    $error("control output high in the cycle after reset");
  end

endmodule

bind rv_core_top rv_core_chk u_chk (
  .clk           (clk),
  .rst_n         (rst_n),
  .inst_valid    (inst_valid),
  .inst_credit   (inst_credit),
  .retire_valid  (retire_valid),
  .retire_credit (retire_credit)
);

// ==== sim/rv_core_model.svh ====
`ifndef rv_core_model_svh
`define rv_core_model_svh

typedef enum logic [3:0] {
  k_add,
  k_sub,
  k_addi,
  k_addw,
  k_slli,
  k_lui,
  k_auipc,
  k_jal,
  k_jalr,
  k_bne,
  k_ld,
  k_lw,
  k_lbu,
  k_sd,
  k_ebreak,
  k_illegal
} kind_e;

typedef struct packed {
  kind_e       kind;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [63:0] imm;
} instr_t;

logic [63:0] m_regs [32];
logic [63:0] m_mem [64];
logic [63:0] m_pc;

task automatic model_reset(input logic [63:0] start_pc);
  for (int i = 0; i < 32; i++) begin
    m_regs[i] = '0;
  end
  for (int i = 0; i < 64; i++) begin
    m_mem[i] = '0;
  end
  m_pc = start_pc;
endtask

// executes one instruction in program order and returns its retire record
task automatic model_step(input instr_t ins, output rv_link_pkg::retire_msg_t rec);
  logic [63:0] a;
  logic [63:0] b;
  logic [63:0] addr;
  logic [63:0] dw;
  logic [31:0] w;
  logic [63:0] val;
  logic        wr;
  a        = m_regs[ins.rs1];
  b        = m_regs[ins.rs2];
  addr     = a + ins.imm;
  dw       = m_mem[addr[8:3]];
  val      = '0;
  wr       = 1'b1;
  rec      = '0;
  rec.pc   = m_pc;
  rec.dnpc = m_pc + 64'd4;
  case (ins.kind)
    k_add:   val = a + b;
    k_sub:   val = a - b;
    k_addi:  val = a + ins.imm;
    k_addw: begin
      w   = a[31:0] + b[31:0];
      val = {{32{w[31]}}, w};
    end
    k_slli:  val = a << ins.imm[5:0];
    k_lui:   val = ins.imm;
    k_auipc: val = m_pc + ins.imm;
    k_jal: begin
      val      = m_pc + 64'd4;
      rec.dnpc = m_pc + ins.imm;
    end
    k_jalr: begin
      val      = m_pc + 64'd4;
      rec.dnpc = addr & ~64'd1;
    end
    k_ld:    val = dw;
    k_lw: begin
      w   = addr[2] ? dw[63:32] : dw[31:0];
      val = {{32{w[31]}}, w};
    end
    k_lbu:   val = (dw >> {addr[2:0], 3'b000}) & 64'hff;
    k_bne: begin
      wr = 1'b0;
      if (a != b) begin
        rec.dnpc = m_pc + ins.imm;
      end
    end
    k_sd: begin
      wr                 = 1'b0;
      m_mem[addr[8:3]]   = b;
    end
    k_ebreak: begin
      wr              = 1'b0;
      rec.halt        = 1'b1;
      rec.halt_status = (m_regs[10] != 64'd0);
    end
    default: wr = 1'b0;
  endcase
  if (wr) begin
    rec.rd    = ins.rd;
    rec.wen   = 1'b1;
    rec.wdata = val;
    if (ins.rd != 5'd0) begin
      m_regs[ins.rd] = val;
    end
  end
  m_pc = rec.dnpc;
endtask

`endif

// ==== sim/tb_rv_core.sv ====
`timescale 1ns/100ps

module tb_rv_core;

  localparam int n_instr     = 600;
  localparam int stall_limit = 500;
  localparam int drain_limit = 1000;

  logic                     clk;
  logic                     rst_n;
  logic                     inst_valid;
  rv_link_pkg::inst_msg_t   inst;
  logic                     inst_credit;
  logic                     retire_credit;
  logic                     retire_valid;
  rv_link_pkg::retire_msg_t retire;

  `include "rv_core_model.svh"

  rv_link_pkg::retire_msg_t exp_q [$];
  string                    name_q [$];
  int                       src_credits;
  int                       held;
  int                       sent;
  int                       stall;
  int                       wait_cnt;
  logic                     follow_load;
  logic [63:0]              follow_addr;
  logic [4:0]               last_rd;

  rv_core_top uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .inst_valid    (inst_valid),
    .inst          (inst),
    .inst_credit   (inst_credit),
    .retire_credit (retire_credit),
    .retire_valid  (retire_valid),
    .retire        (retire)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_retire(input string name, input rv_link_pkg::retire_msg_t exp,
                              input rv_link_pkg::retire_msg_t act);
    rv_link_pkg::retire_msg_t act_m;
    act_m = act;
    // rd and data carry no meaning without a write
    if (!exp.wen) begin
      act_m.rd    = '0;
      act_m.wdata = '0;
    end
    if (act_m !== exp) begin
      stop_run($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_flow(input string name, input logic [63:0] exp_pc,
                            input logic [63:0] exp_dnpc, input logic [63:0] act_pc,
                            input logic [63:0] act_dnpc);
    if ({act_pc, act_dnpc} !== {exp_pc, exp_dnpc}) begin
      stop_run($sformatf("mismatch %s: expected pc %h dnpc %h actual pc %h dnpc %h",
                         name, exp_pc, exp_dnpc, act_pc, act_dnpc));
    end
  endtask

  function automatic logic [63:0] sext(input logic [63:0] v, input int bits);
    logic [63:0] mask;
    mask = ~64'd0 << bits;
    return v[bits-1] ? (v | mask) : (v & ~mask);
  endfunction

  // standard RV64I encodings
  function automatic logic [31:0] encode(input instr_t ins);
    logic [63:0] i;
    logic [31:0] w;
    i = ins.imm;
    case (ins.kind)
      k_add:    w = {7'h00, ins.rs2, ins.rs1, 3'h0, ins.rd, 7'h33};
      k_sub:    w = {7'h20, ins.rs2, ins.rs1, 3'h0, ins.rd, 7'h33};
      k_addw:   w = {7'h00, ins.rs2, ins.rs1, 3'h0, ins.rd, 7'h3b};
      k_addi:   w = {i[11:0], ins.rs1, 3'h0, ins.rd, 7'h13};
      k_slli:   w = {6'h00, i[5:0], ins.rs1, 3'h1, ins.rd, 7'h13};
      k_lui:    w = {i[31:12], ins.rd, 7'h37};
      k_auipc:  w = {i[31:12], ins.rd, 7'h17};
      k_jal:    w = {i[20], i[10:1], i[11], i[19:12], ins.rd, 7'h6f};
      k_jalr:   w = {i[11:0], ins.rs1, 3'h0, ins.rd, 7'h67};
      k_bne:    w = {i[12], i[10:5], ins.rs2, ins.rs1, 3'h1, i[4:1], i[11], 7'h63};
      k_ld:     w = {i[11:0], ins.rs1, 3'h3, ins.rd, 7'h03};
      k_lw:     w = {i[11:0], ins.rs1, 3'h2, ins.rd, 7'h03};
      k_lbu:    w = {i[11:0], ins.rs1, 3'h4, ins.rd, 7'h03};
      k_sd:     w = {i[11:5], ins.rs2, ins.rs1, 3'h3, i[4:0], 7'h23};
      k_ebreak: w = 32'h0010_0073;
      default:  w = 32'h0000_0000;
    endcase
    return w;
  endfunction

  task automatic pick_instr(output instr_t ins);
    int unsigned r;
    int unsigned dw;
    logic [63:0] target;
    ins     = '0;
    ins.rd  = 5'($urandom_range(0, 15));
    ins.rs1 = 5'($urandom_range(0, 15));
    ins.rs2 = 5'($urandom_range(0, 15));
    // lean on the previous result so the bypass gets used
    if ($urandom_range(0, 2) == 0) begin
      ins.rs1 = last_rd;
    end
    r = follow_load ? 66 + $urandom_range(0, 16) : $urandom_range(0, 99);
    case (r) inside
      [0:9]:   ins.kind = k_add;
      [10:15]: ins.kind = k_sub;
      [16:29]: ins.kind = k_addi;
      [30:35]: ins.kind = k_addw;
      [36:41]: ins.kind = k_slli;
      [42:46]: ins.kind = k_lui;
      [47:51]: ins.kind = k_auipc;
      [52:56]: ins.kind = k_jal;
      [57:60]: ins.kind = k_jalr;
      [61:65]: ins.kind = k_bne;
      [66:72]: ins.kind = k_ld;
      [73:77]: ins.kind = k_lw;
      [78:82]: ins.kind = k_lbu;
      [83:94]: ins.kind = k_sd;
      [95:96]: ins.kind = k_ebreak;
      default: ins.kind = k_illegal;
    endcase
    case (ins.kind)
      k_addi, k_jalr:  ins.imm = sext(64'($urandom), 12);
      k_slli:          ins.imm = 64'($urandom_range(0, 63));
      k_lui, k_auipc:  ins.imm = sext({$urandom, 12'h000}, 32);
      k_jal:           ins.imm = sext({$urandom, 1'b0}, 21);
      k_bne:           ins.imm = sext({$urandom, 1'b0}, 13);
      k_ld, k_lw, k_lbu, k_sd: begin
        if (follow_load) begin
          target = follow_addr;
        end else begin
          dw     = ($urandom_range(0, 3) == 0) ? $urandom_range(0, 63) : $urandom_range(0, 7);
          target = 64'(dw * 8);
        end
        if (ins.kind == k_lw) begin
          target[2] = 1'($urandom_range(0, 1));
        end
        if (ins.kind == k_lbu) begin
          target[2:0] = 3'($urandom_range(0, 7));
        end
        // keep the address inside the 512 byte memory
        if (m_regs[ins.rs1] > 64'd511) begin
          ins.rs1 = 5'd0;
        end
        ins.imm = target - m_regs[ins.rs1];
        if (ins.kind == k_sd) begin
          follow_addr = target;
        end
      end
      default: ins.imm = '0;
    endcase
    follow_load = (ins.kind == k_sd) && ($urandom_range(0, 1) == 0);
    last_rd     = ins.rd;
  endtask

  task automatic send_one(input logic ebreak);
    instr_t                   ins;
    rv_link_pkg::retire_msg_t rec;
    if (ebreak) begin
      ins      = '0;
      ins.kind = k_ebreak;
    end else begin
      pick_instr(ins);
    end
    model_step(ins, rec);
    inst_valid <= 1'b1;
    inst.pc    <= rec.pc;
    inst.word  <= encode(ins);
    src_credits--;
    exp_q.push_back(rec);
    name_q.push_back($sformatf("instr %0d %s", sent, ins.kind.name()));
    sent++;
  endtask

  task automatic return_credit(input logic slow);
    if (held > 0 && $urandom_range(0, 7) < (slow ? 1 : 6)) begin
      retire_credit <= 1'b1;
      held--;
    end else begin
      retire_credit <= 1'b0;
    end
  endtask

  // retire consumer sampling on the falling edge
  always @(negedge clk) begin : monitor
    rv_link_pkg::retire_msg_t exp;
    string                    name;
    if (rst_n) begin
      if (inst_credit) begin
        src_credits++;
      end
      if (uut.u_chk.errors != 0) begin
        stop_run("protocol assertion failed on the credit links");
      end else if (retire_valid) begin
        if (exp_q.size() == 0) begin
          stop_run("retire record arrived with no instruction outstanding");
        end else begin
          exp  = exp_q.pop_front();
          name = name_q.pop_front();
          check_flow(name, exp.pc, exp.dnpc, retire.pc, retire.dnpc);
          check_retire(name, exp, retire);
          held++;
        end
      end
    end
  end

  initial begin
    void'($urandom(32'h8d15d6cf));
    rst_n         = 1'b0;
    inst_valid    = 1'b0;
    inst          = '0;
    retire_credit = 1'b0;
    src_credits   = rv_link_pkg::inst_credits;
    held          = 0;
    sent          = 0;
    stall         = 0;
    follow_load   = 1'b0;
    follow_addr   = '0;
    last_rd       = 5'd0;
    model_reset(64'h0000_0000_8000_0000);
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // the program opens and closes with ebreak
    while (sent < n_instr) begin
      @(posedge clk);
      return_credit(((sent / 100) % 2) == 1);
      if (src_credits > 0 && $urandom_range(0, 3) != 0) begin
        send_one(sent == 0 || sent == n_instr - 1);
        stall = 0;
      end else begin
        inst_valid <= 1'b0;
        stall++;
        if (stall > stall_limit) begin
          stop_run("timeout: source received no instruction credit");
        end
      end
    end

    wait_cnt = 0;
    do begin
      @(posedge clk);
      inst_valid <= 1'b0;
      return_credit(1'b0);
      wait_cnt++;
      if (wait_cnt > drain_limit) begin
        stop_run("timeout: retire records still outstanding after the last instruction");
      end
    end while (exp_q.size() != 0);

    if (uut.u_chk.errors != 0) begin
      stop_run("protocol assertion failed on the credit links");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// ==== all.f ====
+incdir+sim
hdl/rv_isa_pkg.sv
hdl/rv_link_pkg.sv
hdl/credit_fifo.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_core_top.sv
sim/rv_core_chk.sv
sim/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - hdl/rv_isa_pkg.sv
  - hdl/rv_link_pkg.sv
  - hdl/credit_fifo.sv
  - hdl/rv_decode.sv
  - hdl/rv_execute.sv
  - hdl/rv_result.sv
  - hdl/rv_core_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/rv_core_chk.sv
      - sim/tb_rv_core.sv
